// ==== dnc_fixed_pkg.sv ====
// Numeric format of the precedence weighting datapath
// Unsigned fixed point words shared by every unit through module parameters

package dnc_fixed_pkg;

  //////////////////////////////
  // Word format
  //////////////////////////////

  // Default width of every data word on the bus
  // Weights, precedence values, the summed weight and the retain factor
  // all use this width
  parameter int DATA_SIZE_DEFAULT = 16;

  // Default number of fraction bits
  // 12 of 16 bits gives an unsigned Q4.12 word
  // 1.0 is then 16'h1000 and the largest value just under 16.0
  parameter int FRAC_BITS_DEFAULT = 12;

  //////////////////////////////
  // Format rules
  //////////////////////////////

  // FRAC_BITS must stay below DATA_SIZE so that 1.0 fits in one word
  // Products are formed at twice the word width
  // The FRAC_BITS lowest product bits are dropped without rounding
  // Results that do not fit saturate at the all ones word

  // Weights live in [0, 1.0] and their sum is clamped to 1.0,
  // so the retain factor 1.0 - sum never goes below zero

  // No modulo arithmetic anywhere in the datapath

endpackage

// ==== dnc_ctrl_pkg.sv ====
// Control definitions of the precedence weighting datapath
// FSM encoding of the update unit and the default vector depth

package dnc_ctrl_pkg;

  //////////////////////////////
  // Vector depth
  //////////////////////////////

  // Memory locations the element buffer holds per stream
  parameter int MAX_N_DEFAULT = 16;

  //////////////////////////////
  // Update unit FSM
  //////////////////////////////

  typedef enum logic [2:0] {
    // Waiting for START
    IDLE_STATE    = 3'd0,
    // Waiting for the sum and both input vectors
    COLLECT_STATE = 3'd1,
    // One cycle to form 1.0 - sum, first read issued here
    RETAIN_STATE  = 3'd2,
    // Reads issued back to back, results streaming out
    STREAM_STATE  = 3'd3,
    // Last element on P_OUT, READY follows
    ENDER_STATE   = 3'd4
  } update_state_t;

endpackage

// ==== dnc_write_summation.sv ====
// Write summation unit, reduces the N write weights of one job to a scalar
// Sum saturates at 1.0 and is held with sum_done until the next START

module dnc_write_summation #(
  parameter int DATA_SIZE = dnc_fixed_pkg::DATA_SIZE_DEFAULT,
  parameter int FRAC_BITS = dnc_fixed_pkg::FRAC_BITS_DEFAULT
) (
  input  logic                 CLK,
  input  logic                 RST,

  // Job control
  input  logic                 START,
  input  logic                 W_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] SIZE_N_IN,

  // Write weight stream
  input  logic [DATA_SIZE-1:0] W_IN,

  // Towards the update unit
  output logic [DATA_SIZE-1:0] sum_out,
  output logic                 sum_done
);

  //////////////////////////////
  // Constants and signals
  //////////////////////////////

  // 1.0 at accumulator width
  localparam logic [DATA_SIZE:0] ONE = {{DATA_SIZE{1'b0}}, 1'b1} << FRAC_BITS;

  // Vector length captured at START
  logic [DATA_SIZE-1:0] size_n;
  // Weights taken so far
  logic [DATA_SIZE-1:0] w_count;

  // One guard bit above the word
  logic [DATA_SIZE:0]   acc;
  logic [DATA_SIZE:0]   acc_add;
  logic [DATA_SIZE:0]   acc_next;

  logic                 w_take;

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Strobes after the Nth are not counted
  assign w_take = W_IN_ENABLE && !sum_done;

  // acc never exceeds 1.0, so the guard bit covers the carry
  assign acc_add  = acc + {1'b0, W_IN};
  assign acc_next = (acc_add > ONE) ? ONE : acc_add;

  // Clamped sum always fits the word
  assign sum_out = acc[DATA_SIZE-1:0];

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_n   <= '0;
      w_count  <= '0;
      acc      <= '0;
      sum_done <= 1'b0;
    end else if (START) begin
      // New job, everything from the last one dropped
      size_n   <= SIZE_N_IN;
      w_count  <= '0;
      acc      <= '0;
      sum_done <= 1'b0;
    end else if (w_take) begin
      acc     <= acc_next;
      w_count <= w_count + 1'b1;
      // Level rises in the cycle after the Nth strobe
      if (w_count + 1'b1 == size_n) begin
        sum_done <= 1'b1;
      end
    end
  end

  // Host keeps the W stream quiet once the sum is complete
  a_no_w_after_done : assert property (
    @(posedge CLK) disable iff (RST)
    (sum_done && !START) |-> !W_IN_ENABLE
  );

endmodule

// ==== dnc_element_buffer.sv ====
// Element buffer, stores the write and previous precedence vectors of a job
// Filled in arrival order by two independent streams, read back one cycle late

module dnc_element_buffer #(
  parameter int DATA_SIZE = dnc_fixed_pkg::DATA_SIZE_DEFAULT,
  parameter int MAX_N     = dnc_ctrl_pkg::MAX_N_DEFAULT
) (
  input  logic                     CLK,
  input  logic                     RST,

  // Job control and input strobes
  input  logic                     START,
  input  logic                     W_IN_ENABLE,
  input  logic                     P_IN_ENABLE,
  input  logic [DATA_SIZE-1:0]     SIZE_N_IN,

  // Input vectors, element j = 0 first
  input  logic [DATA_SIZE-1:0]     W_IN,
  input  logic [DATA_SIZE-1:0]     P_IN,

  // Read port driven by the update unit
  input  logic                     rd_en,
  input  logic [$clog2(MAX_N)-1:0] rd_addr,
  output logic [DATA_SIZE-1:0]     rd_w,
  output logic [DATA_SIZE-1:0]     rd_p,

  // Both vectors complete
  output logic                     buffer_full
);

  //////////////////////////////
  // Constants and signals
  //////////////////////////////

  localparam int ADDR_SIZE = $clog2(MAX_N);
  // Counters must reach MAX_N itself
  localparam int CNT_SIZE  = $clog2(MAX_N + 1);

  // Element storage
  logic [DATA_SIZE-1:0] w_mem [MAX_N];
  logic [DATA_SIZE-1:0] p_mem [MAX_N];

  // Job open and still filling
  logic                 busy;
  logic [CNT_SIZE-1:0]  size_n;

  // Write counters, one per stream
  logic [CNT_SIZE-1:0]  w_count;
  logic [CNT_SIZE-1:0]  p_count;
  logic [CNT_SIZE-1:0]  w_count_next;
  logic [CNT_SIZE-1:0]  p_count_next;

  logic                 w_done;
  logic                 p_done;
  logic                 w_take;
  logic                 p_take;

  //////////////////////////////
  // Write side
  //////////////////////////////

  assign w_done = (w_count == size_n);
  assign p_done = (p_count == size_n);

  // A strobe is taken only inside an open job and below N
  assign w_take = busy && W_IN_ENABLE && !w_done && !START;
  assign p_take = busy && P_IN_ENABLE && !p_done && !START;

  assign w_count_next = w_count + CNT_SIZE'(w_take);
  assign p_count_next = p_count + CNT_SIZE'(p_take);

  // Storage, written at the stream's own counter
  always_ff @(posedge CLK) begin
    if (w_take) begin
      w_mem[w_count[ADDR_SIZE-1:0]] <= W_IN;
    end
    if (p_take) begin
      p_mem[p_count[ADDR_SIZE-1:0]] <= P_IN;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy        <= 1'b0;
      size_n      <= '0;
      w_count     <= '0;
      p_count     <= '0;
      buffer_full <= 1'b0;
    end else if (START) begin
      busy        <= 1'b1;
      size_n      <= SIZE_N_IN[CNT_SIZE-1:0];
      w_count     <= '0;
      p_count     <= '0;
      buffer_full <= 1'b0;
    end else begin
      w_count <= w_count_next;
      p_count <= p_count_next;
      // Next counts used so the flag rises one cycle after the last strobe
      if (busy && (w_count_next == size_n) && (p_count_next == size_n)) begin
        busy        <= 1'b0;
        buffer_full <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // Read side
  //////////////////////////////

  // Registered read, data valid the cycle after rd_en
  always_ff @(posedge CLK) begin
    if (rd_en) begin
      rd_w <= w_mem[rd_addr];
      rd_p <= p_mem[rd_addr];
    end
  end

  // Each stream delivers exactly N elements
  a_w_stream_bound : assert property (
    @(posedge CLK) disable iff (RST)
    (w_done && !START) |-> !W_IN_ENABLE
  );
  a_p_stream_bound : assert property (
    @(posedge CLK) disable iff (RST)
    (p_done && !START) |-> !P_IN_ENABLE
  );

  // Length must fit the storage
  a_size_in_range : assert property (
    @(posedge CLK) disable iff (RST)
    START |-> (SIZE_N_IN >= 1) && (SIZE_N_IN <= MAX_N)
  );

endmodule

// ==== dnc_precedence_update.sv ====
// Precedence update unit, waits for the sum and the buffered vectors of a job
// then streams p(j) = w(j) + (1.0 - sum) * p_prev(j), one element per cycle

module dnc_precedence_update #(
  parameter int DATA_SIZE = dnc_fixed_pkg::DATA_SIZE_DEFAULT,
  parameter int FRAC_BITS = dnc_fixed_pkg::FRAC_BITS_DEFAULT,
  parameter int MAX_N     = dnc_ctrl_pkg::MAX_N_DEFAULT
) (
  input  logic                     CLK,
  input  logic                     RST,

  input  logic                     START,

  // From the summation unit
  input  logic [DATA_SIZE-1:0]     sum_out,
  input  logic                     sum_done,

  // Buffer handshake and read port
  input  logic                     buffer_full,
  output logic                     rd_en,
  output logic [$clog2(MAX_N)-1:0] rd_addr,
  input  logic [DATA_SIZE-1:0]     rd_w,
  input  logic [DATA_SIZE-1:0]     rd_p,

  input  logic [DATA_SIZE-1:0]     SIZE_N_IN,

  // Result stream
  output logic [DATA_SIZE-1:0]     P_OUT,
  output logic                     P_OUT_ENABLE,
  output logic                     READY
);

  import dnc_ctrl_pkg::*;

  //////////////////////////////
  // Constants and signals
  //////////////////////////////

  localparam int ADDR_SIZE = $clog2(MAX_N);
  localparam int CNT_SIZE  = $clog2(MAX_N + 1);

  // 1.0 at word width
  localparam logic [DATA_SIZE-1:0] ONE = {{(DATA_SIZE-1){1'b0}}, 1'b1} << FRAC_BITS;

  update_state_t        state;

  logic [CNT_SIZE-1:0]  size_n;
  // Next element to read
  logic [CNT_SIZE-1:0]  rd_ptr;
  // Elements already sent
  logic [CNT_SIZE-1:0]  out_cnt;
  // Read data valid this cycle
  logic                 rd_valid;
  logic                 last_out;

  // 1.0 - sum, fixed for the whole job
  logic [DATA_SIZE-1:0]   retain;
  logic [2*DATA_SIZE-1:0] product;
  logic [DATA_SIZE:0]     mac_sum;
  logic [DATA_SIZE-1:0]   mac_sat;

  //////////////////////////////
  // Read stage
  //////////////////////////////

  // First read goes out in RETAIN so data meets the fresh retain factor
  assign rd_en   = ((state == RETAIN_STATE) || (state == STREAM_STATE)) &&
                   (rd_ptr != size_n);
  assign rd_addr = rd_ptr[ADDR_SIZE-1:0];

  //////////////////////////////
  // Multiply-add stage
  //////////////////////////////

  // retain is at most 1.0, so the shifted product never exceeds rd_p
  assign product = rd_p * retain;
  assign mac_sum = {1'b0, rd_w} + {1'b0, product[FRAC_BITS +: DATA_SIZE]};
  // Clip to the largest word
  assign mac_sat = mac_sum[DATA_SIZE] ? '1 : mac_sum[DATA_SIZE-1:0];

  assign last_out = (out_cnt + 1'b1 == size_n);

  always_ff @(posedge CLK) begin
    if (state == RETAIN_STATE) begin
      retain <= ONE - sum_out;
    end
  end

  //////////////////////////////
  // FSM and outputs
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= IDLE_STATE;
      size_n       <= '0;
      rd_ptr       <= '0;
      out_cnt      <= '0;
      rd_valid     <= 1'b0;
      P_OUT        <= '0;
      P_OUT_ENABLE <= 1'b0;
      READY        <= 1'b0;
    end else begin
      // Two stage pipe, read then compute
      rd_valid     <= rd_en;
      P_OUT_ENABLE <= rd_valid;
      // Pulse the cycle after the last P_OUT_ENABLE
      READY        <= (state == ENDER_STATE);

      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (rd_valid) begin
        P_OUT   <= mac_sat;
        out_cnt <= out_cnt + 1'b1;
      end

      case (state)
        IDLE_STATE : begin
          if (START) begin
            size_n  <= SIZE_N_IN[CNT_SIZE-1:0];
            rd_ptr  <= '0;
            out_cnt <= '0;
            state   <= COLLECT_STATE;
          end
        end
        // Side flags were cleared by START, wait for both
        COLLECT_STATE : begin
          if (sum_done && buffer_full) begin
            state <= RETAIN_STATE;
          end
        end
        RETAIN_STATE : begin
          state <= STREAM_STATE;
        end
        STREAM_STATE : begin
          if (rd_valid && last_out) begin
            state <= ENDER_STATE;
          end
        end
        ENDER_STATE : begin
          state <= IDLE_STATE;
        end
        default : begin
          state <= IDLE_STATE;
        end
      endcase
    end
  end

  // Outputs only inside a job
  a_no_out_idle : assert property (
    @(posedge CLK) disable iff (RST)
    (state == IDLE_STATE) |-> !P_OUT_ENABLE
  );

  // READY strictly after the stream
  a_ready_after_stream : assert property (
    @(posedge CLK) disable iff (RST)
    !(READY && P_OUT_ENABLE)
  );

endmodule

// ==== dnc_precedence_weighting.sv ====
// Precedence weighting of a DNC write head, one time step per START
// Host streams W and previous P, results come back on P_OUT with READY after

module dnc_precedence_weighting #(
  parameter int DATA_SIZE = dnc_fixed_pkg::DATA_SIZE_DEFAULT,
  parameter int FRAC_BITS = dnc_fixed_pkg::FRAC_BITS_DEFAULT,
  parameter int MAX_N     = dnc_ctrl_pkg::MAX_N_DEFAULT
) (
  input  logic                 CLK,
  input  logic                 RST,

  // Control
  input  logic                 START,
  output logic                 READY,

  // Element strobes, j = 0 to N-1
  input  logic                 W_IN_ENABLE,
  input  logic                 P_IN_ENABLE,
  output logic                 P_OUT_ENABLE,

  // Data
  input  logic [DATA_SIZE-1:0] SIZE_N_IN,
  input  logic [DATA_SIZE-1:0] W_IN,
  input  logic [DATA_SIZE-1:0] P_IN,
  output logic [DATA_SIZE-1:0] P_OUT
);

  //////////////////////////////
  // Internal wires
  //////////////////////////////

  // Summation to update
  logic [DATA_SIZE-1:0]     sum_out;
  logic                     sum_done;

  // Buffer to update
  logic                     buffer_full;
  logic                     rd_en;
  logic [$clog2(MAX_N)-1:0] rd_addr;
  logic [DATA_SIZE-1:0]     rd_w;
  logic [DATA_SIZE-1:0]     rd_p;

  //////////////////////////////
  // Units
  //////////////////////////////

  // Sum of w(t;i) over all locations
  dnc_write_summation #(
    .DATA_SIZE (DATA_SIZE),
    .FRAC_BITS (FRAC_BITS)
  ) write_summation (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .W_IN_ENABLE (W_IN_ENABLE),
    .SIZE_N_IN   (SIZE_N_IN),
    .W_IN        (W_IN),
    .sum_out     (sum_out),
    .sum_done    (sum_done)
  );

  // Holds w(t) and p(t-1) while the sum forms
  dnc_element_buffer #(
    .DATA_SIZE (DATA_SIZE),
    .MAX_N     (MAX_N)
  ) element_buffer (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .W_IN_ENABLE (W_IN_ENABLE),
    .P_IN_ENABLE (P_IN_ENABLE),
    .SIZE_N_IN   (SIZE_N_IN),
    .W_IN        (W_IN),
    .P_IN        (P_IN),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_w        (rd_w),
    .rd_p        (rd_p),
    .buffer_full (buffer_full)
  );

  // Retain factor and output stream
  dnc_precedence_update #(
    .DATA_SIZE (DATA_SIZE),
    .FRAC_BITS (FRAC_BITS),
    .MAX_N     (MAX_N)
  ) precedence_update (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .sum_out      (sum_out),
    .sum_done     (sum_done),
    .buffer_full  (buffer_full),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_w         (rd_w),
    .rd_p         (rd_p),
    .SIZE_N_IN    (SIZE_N_IN),
    .P_OUT        (P_OUT),
    .P_OUT_ENABLE (P_OUT_ENABLE),
    .READY        (READY)
  );

endmodule

// ==== dnc_precedence_weighting_tb.sv ====
// Self-checking testbench for the DNC precedence weighting top level
// Applies a stimulus table row by row and checks P_OUT against the update rule

module dnc_precedence_weighting_tb;

  import dnc_fixed_pkg::*;
  import dnc_ctrl_pkg::*;

  localparam int DATA_SIZE = DATA_SIZE_DEFAULT;
  localparam int FRAC_BITS = FRAC_BITS_DEFAULT;
  localparam int MAX_N     = MAX_N_DEFAULT;
  localparam int ONE       = 1 << FRAC_BITS;
  localparam logic [31:0] MAX_WORD = 32'((2 ** DATA_SIZE) - 1);
  localparam int NUM_ROWS  = 10;

  // Arrival modes
  localparam int MODE_TOGETHER = 0;
  localparam int MODE_W_FIRST  = 1;
  localparam int MODE_P_FIRST  = 2;
  localparam int MODE_GAPS     = 3;
  // Vector sources
  localparam int KIND_EXPLICIT = 0;
  localparam int KIND_RANDOM   = 1;
  localparam int KIND_SATURATE = 2;
  localparam int KIND_ZERO_W   = 3;
  localparam int KIND_REPEAT   = 4;

  logic                 CLK;
  logic                 RST;
  logic                 START;
  logic                 W_IN_ENABLE;
  logic                 P_IN_ENABLE;
  logic [DATA_SIZE-1:0] SIZE_N_IN;
  logic [DATA_SIZE-1:0] W_IN;
  logic [DATA_SIZE-1:0] P_IN;
  logic                 READY;
  logic                 P_OUT_ENABLE;
  logic [DATA_SIZE-1:0] P_OUT;

  // Stimulus table
  int tab_n    [NUM_ROWS];
  int tab_mode [NUM_ROWS];
  int tab_kind [NUM_ROWS];

  logic [DATA_SIZE-1:0] w_vec    [MAX_N];
  logic [DATA_SIZE-1:0] p_vec    [MAX_N];
  logic [DATA_SIZE-1:0] exp_vec  [MAX_N];
  logic [DATA_SIZE-1:0] got_vec  [MAX_N];
  logic [DATA_SIZE-1:0] prev_got [MAX_N];

  logic [31:0] rng;
  int          value_errors;
  int          other_errors;
  int          out_count;
  int          ready_count;
  logic        job_open;

  dnc_precedence_weighting #(
    .DATA_SIZE (DATA_SIZE),
    .FRAC_BITS (FRAC_BITS),
    .MAX_N     (MAX_N)
  ) dnc_precedence_weighting_i (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .READY        (READY),
    .W_IN_ENABLE  (W_IN_ENABLE),
    .P_IN_ENABLE  (P_IN_ENABLE),
    .P_OUT_ENABLE (P_OUT_ENABLE),
    .SIZE_N_IN    (SIZE_N_IN),
    .W_IN         (W_IN),
    .P_IN         (P_IN),
    .P_OUT        (P_OUT)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic set_row(input int row, input int n, input int mode, input int kind);
    tab_n[row]    = n;
    tab_mode[row] = mode;
    tab_kind[row] = kind;
  endtask

  // Repeat rows keep N of the row before them
  task automatic load_table;
    set_row(0, 4, MODE_TOGETHER, KIND_EXPLICIT);
    set_row(1, 1, MODE_TOGETHER, KIND_RANDOM);
    set_row(2, 7, MODE_TOGETHER, KIND_RANDOM);
    set_row(3, 7, MODE_W_FIRST, KIND_REPEAT);
    set_row(4, 7, MODE_P_FIRST, KIND_REPEAT);
    set_row(5, 7, MODE_GAPS, KIND_REPEAT);
    set_row(6, MAX_N, MODE_GAPS, KIND_RANDOM);
    set_row(7, MAX_N, MODE_TOGETHER, KIND_SATURATE);
    set_row(8, 5, MODE_P_FIRST, KIND_ZERO_W);
    set_row(9, MAX_N, MODE_W_FIRST, KIND_RANDOM);
  endtask

  task automatic make_vectors(input int row);
    int step;
    step = ONE / tab_n[row];
    for (int j = 0; j < tab_n[row]; j++) begin
      rng = xorshift(rng);
      case (tab_kind[row])
        // Explicit values, sum 0x780, one P at the top of the range
        KIND_EXPLICIT : begin
          w_vec[j] = 16'h0400 >> j;
          p_vec[j] = (j == 2) ? 16'hffff : 16'h1000 >> j;
        end
        // Each weight in [step/2, step), sum just under 1.0
        KIND_RANDOM : begin
          w_vec[j] = step / 2 + rng % (step / 2);
          rng      = xorshift(rng);
          p_vec[j] = rng[DATA_SIZE-1:0];
        end
        // Each weight above step, sum beyond 1.0
        KIND_SATURATE : begin
          w_vec[j] = step + 1 + rng % step;
          rng      = xorshift(rng);
          p_vec[j] = rng[DATA_SIZE-1:0];
        end
        KIND_ZERO_W : begin
          w_vec[j] = '0;
          p_vec[j] = rng[DATA_SIZE-1:0];
        end
        default : begin
        end
      endcase
    end
  endtask

  // p(j) = w(j) + ((1.0 - clamped sum) * p_prev(j) >> FRAC_BITS), saturated
  task automatic compute_expected(input int n);
    int          sum;
    logic [31:0] retain;
    logic [31:0] prod;
    logic [31:0] res;
    sum = 0;
    for (int j = 0; j < n; j++) begin
      sum = sum + w_vec[j];
    end
    if (sum > ONE) begin
      sum = ONE;
    end
    retain = ONE - sum;
    for (int j = 0; j < n; j++) begin
      prod       = p_vec[j] * retain;
      res        = w_vec[j] + (prod >> FRAC_BITS);
      exp_vec[j] = (res > MAX_WORD) ? MAX_WORD[DATA_SIZE-1:0] : res[DATA_SIZE-1:0];
    end
  endtask

  task automatic drive_row(input int row);
    int   n;
    int   wi;
    int   pi;
    logic sw;
    logic sp;
    n  = tab_n[row];
    wi = 0;
    pi = 0;
    @(posedge CLK);
    job_open    = 1'b1;
    out_count   = 0;
    ready_count = 0;
    START     <= 1'b1;
    SIZE_N_IN <= DATA_SIZE'(n);
    while ((wi < n) || (pi < n)) begin
      @(posedge CLK);
      rng = xorshift(rng);
      case (tab_mode[row])
        MODE_TOGETHER : begin
          sw = (wi < n);
          sp = (pi < n);
        end
        MODE_W_FIRST : begin
          sw = (wi < n);
          sp = (wi == n) && (pi < n);
        end
        MODE_P_FIRST : begin
          sp = (pi < n);
          sw = (pi == n) && (wi < n);
        end
        default : begin
          sw = (wi < n) && rng[0];
          sp = (pi < n) && rng[1];
        end
      endcase
      START       <= 1'b0;
      W_IN_ENABLE <= sw;
      P_IN_ENABLE <= sp;
      if (sw) begin
        W_IN <= w_vec[wi];
        wi++;
      end
      if (sp) begin
        P_IN <= p_vec[pi];
        pi++;
      end
    end
    @(posedge CLK);
    START       <= 1'b0;
    W_IN_ENABLE <= 1'b0;
    P_IN_ENABLE <= 1'b0;
  endtask

  // Quiet cycles after READY catch late outputs
  task automatic wait_ready(input int row);
    int cycles;
    cycles = 0;
    while ((ready_count == 0) && (cycles < 8 * MAX_N + 100)) begin
      @(posedge CLK);
      cycles++;
    end
    if (ready_count == 0) begin
      other_errors++;
      $display("Row %0d: READY never came after the inputs", row);
    end
    repeat (5) @(posedge CLK);
  endtask

  task automatic check_row(input int row);
    int n;
    n = tab_n[row];
    if (out_count != n) begin
      other_errors++;
      $display("Row %0d: %0d outputs seen where %0d were due", row, out_count, n);
    end
    if (ready_count != 1) begin
      other_errors++;
      $display("Row %0d: %0d READY pulses where one was due", row, ready_count);
    end
    for (int j = 0; (j < n) && (j < out_count); j++) begin
      if (got_vec[j] !== exp_vec[j]) begin
        value_errors++;
        $display("Error P_OUT[%0d] row %0d: got %h, expected %h", j, row, got_vec[j],
                 exp_vec[j]);
      end
      if ((tab_kind[row] == KIND_REPEAT) && (got_vec[j] !== prev_got[j])) begin
        value_errors++;
        $display("Error P_OUT[%0d] row %0d: got %h, previous mode gave %h", j, row,
                 got_vec[j], prev_got[j]);
      end
      prev_got[j] = got_vec[j];
    end
  endtask

  //////////////////////////////
  // Clock, monitor, watchdog
  //////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Outputs sampled mid cycle
  always @(negedge CLK) begin
    if (RST) begin
      if (READY || P_OUT_ENABLE) begin
        other_errors++;
        $display("READY or P_OUT_ENABLE high during reset");
      end
    end else begin
      if (P_OUT_ENABLE) begin
        if (!job_open) begin
          other_errors++;
          $display("P_OUT_ENABLE high outside a job");
        end else if (out_count < MAX_N) begin
          got_vec[out_count] = P_OUT;
        end
        out_count++;
      end
      if (READY) begin
        if (!job_open) begin
          other_errors++;
          $display("READY high outside a job");
        end
        ready_count++;
        job_open = 1'b0;
      end
    end
  end

  initial begin
    int limit;
    @(posedge CLK);
    limit = 1000;
    for (int r = 0; r < NUM_ROWS; r++) begin
      limit = limit + 8 * tab_n[r];
    end
    repeat (limit) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, run did not finish", limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    RST          = 1'b1;
    START        = 1'b0;
    W_IN_ENABLE  = 1'b0;
    P_IN_ENABLE  = 1'b0;
    SIZE_N_IN    = '0;
    W_IN         = '0;
    P_IN         = '0;
    rng          = 32'h023da13c;
    value_errors = 0;
    other_errors = 0;
    out_count    = 0;
    ready_count  = 0;
    job_open     = 1'b0;
    load_table();
    repeat (16) @(posedge CLK);
    RST <= 1'b0;
    // Idle after reset, outputs must stay low
    repeat (4) @(posedge CLK);
    for (int r = 0; r < NUM_ROWS; r++) begin
      make_vectors(r);
      compute_expected(tab_n[r]);
      drive_row(r);
      wait_ready(r);
      check_row(r);
    end
    $display("Errors: %0d value, %0d protocol", value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
dnc_fixed_pkg.sv
dnc_ctrl_pkg.sv
dnc_write_summation.sv
dnc_element_buffer.sv
dnc_precedence_update.sv
dnc_precedence_weighting.sv
dnc_precedence_weighting_tb.sv
